// File: tcp_pull_echo.f
+incdir+source
source/mac_stream_pkg.sv
source/echo_header_pkg.sv
source/rx_frame_admit.sv
source/packet_queue.sv
source/echo_responder.sv
source/echo_subsystem_top.sv
verification/echo_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the echo testbench with Verilator, runs it and checks its verdict.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module echo_tb -Mdir obj_dir -f tcp_pull_echo.f \
    && ./obj_dir/Vecho_tb | tee /dev/stderr | grep -qx "all tests passed" \
    && { echo "simulation result: pass"; exit 0; } \
    || { echo "simulation result: fail"; exit 1; }

// File: verification/echo_tb.sv
`default_nettype none
`include "echo_defs.svh"

module echo_tb;

    logic                               clk;
    logic                               rst_n;
    logic                               rx_val;
    mac_stream_pkg::mac_beat_t          rx_beat;
    logic                               tx_val;
    mac_stream_pkg::mac_beat_t          tx_beat;
    logic   [`MTU_SIZE_W-1:0]           tx_frame_size;
    logic   [15:0]                      drop_count;

    logic   [31:0]                      lfsr_state = 32'hb80f_2ff9;
    mac_stream_pkg::mac_beat_t          exp_beats [$];
    logic   [`MTU_SIZE_W-1:0]           exp_sizes [$];

    int errors = 0;
    int timeouts = 0;
    int frames_in = 0;
    int frames_out = 0;
    int model_drops = 0;
    int occ = 0;            // beats held in the beat queue after the last edge.
    int nsizes = 0;         // sizes held in the size queue after the last edge.
    int pend_wr = 0;
    int pend_push = 0;
    int beat_count = 0;
    logic model_keep = 1'b0;

    echo_subsystem_top dut (
         .clk           (clk            )
        ,.rst_n         (rst_n          )
        ,.rx_val        (rx_val         )
        ,.rx_beat       (rx_beat        )
        ,.tx_val        (tx_val         )
        ,.tx_beat       (tx_beat        )
        ,.tx_frame_size (tx_frame_size  )
        ,.drop_count    (drop_count     )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////
    // helpers.
    ////////////////////////////////////////

    task automatic report_error(input string msg);
        errors = errors + 1;
        $display("Error at time %0t: %s", $time, msg);
    endtask

    // one lfsr step per bit taken.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'hd000_0001 : 32'h0);
        end
        return v;
    endfunction

    task automatic send_frame(input int nbeats, input logic [2:0] pad);
        mac_stream_pkg::mac_beat_t      beat;
        echo_header_pkg::first_beat_u   hdr;
        for (int i = 0; i < nbeats; i++) begin
            if (i == 0) begin
                hdr.hdr.dst_id = 16'(take_bits(16));
                hdr.hdr.src_id = 16'(take_bits(16));
                hdr.hdr.ethertype = 16'(take_bits(16));
                hdr.hdr.tag = 16'(take_bits(16));
                beat.data = hdr.raw;
            end else begin
                beat.data = {take_bits(32), take_bits(32)};
            end
            beat.startframe = (i == 0);
            beat.endframe = (i == nbeats - 1);
            beat.padbytes = beat.endframe ? pad : '0;
            @(posedge clk);
            rx_val <= 1'b1;
            rx_beat <= beat;
        end
    endtask

    task automatic send_random_frame();
        send_frame(1 + int'(take_bits(4)), 3'(take_bits(3)));
    endtask

    task automatic go_idle();
        @(posedge clk);
        rx_val <= 1'b0;
    endtask

    task automatic wait_drain(input string what);
        int cycles;
        cycles = 0;
        while ((exp_beats.size() != 0 || tx_val) && cycles < 400) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_beats.size() != 0 || tx_val) begin
            timeouts = timeouts + 1;
            $display("timeout: %s never finished leaving the transmit side", what);
        end
    endtask

    ////////////////////////////////////////
    // reference model and output checks.
    ////////////////////////////////////////

    always @(negedge clk) begin
        mac_stream_pkg::mac_beat_t      exp_beat;
        echo_header_pkg::first_beat_u   hdr;
        echo_header_pkg::first_beat_u   swp;
        logic   [`MTU_SIZE_W-1:0]       exp_size;
        if (rst_n) begin
            // a transmit beat was read from the queue on the edge that opened this cycle.
            occ = occ + pend_wr - (tx_val ? 1 : 0);
            nsizes = nsizes + pend_push - ((tx_val && tx_beat.startframe) ? 1 : 0);
            pend_wr = 0;
            pend_push = 0;
            assert (int'(drop_count) == model_drops) else
                report_error($sformatf("drop_count %0d, expected %0d", drop_count, model_drops));

            if (tx_val) begin
                assert (exp_beats.size() != 0) else
                    report_error("transmit beat seen while no frame was expected");
                if (exp_beats.size() != 0) begin
                    exp_beat = exp_beats.pop_front();
                    assert (tx_beat == exp_beat) else
                        report_error($sformatf("tx_beat %h, expected %h", tx_beat, exp_beat));
                    if (tx_beat.startframe) begin
                        frames_out++;
                        exp_size = (exp_sizes.size() != 0) ? exp_sizes.pop_front() : '0;
                        assert (tx_frame_size == exp_size) else
                            report_error($sformatf("tx_frame_size %0d, expected %0d",
                                                   tx_frame_size, exp_size));
                    end
                end
            end

            if (rx_val) begin
                if (rx_beat.startframe) begin
                    frames_in++;
                    beat_count = 0;
                    model_keep = ((1 << `QUEUE_LOG_ELS) - occ >= `MAX_FRAME_BEATS)
                                 && (nsizes < (1 << `SIZE_QUEUE_LOG_ELS));
                    if (!model_keep) begin
                        model_drops++;
                    end
                end
                if (model_keep) begin
                    beat_count++;
                    pend_wr = 1;
                    exp_beat = rx_beat;
                    if (rx_beat.startframe) begin
                        hdr.raw = rx_beat.data;
                        swp = hdr;
                        swp.hdr.dst_id = hdr.hdr.src_id;    // the echo swaps the ids.
                        swp.hdr.src_id = hdr.hdr.dst_id;
                        exp_beat.data = swp.raw;
                    end
                    exp_beats.push_back(exp_beat);
                    if (rx_beat.endframe) begin
                        pend_push = 1;
                        exp_sizes.push_back(`MTU_SIZE_W'(beat_count * 8 - int'(rx_beat.padbytes)));
                    end
                end
            end
        end
    end

    // output framing, so that no partial frame can leave.
    inside_frame: assert property (@(posedge clk) disable iff (!rst_n)
        tx_val && !tx_beat.endframe |=> tx_val && !tx_beat.startframe)
        else report_error("a frame on the transmit side broke off or restarted before its end");

    after_end: assert property (@(posedge clk) disable iff (!rst_n)
        tx_val && tx_beat.endframe |=> !tx_val || tx_beat.startframe)
        else report_error("a beat followed an end beat without a start beat");

    after_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !tx_val |=> !tx_val || tx_beat.startframe)
        else report_error("transmit resumed without a start beat");

    ////////////////////////////////////////
    // stimulus.
    ////////////////////////////////////////

    initial begin
        rst_n = 1'b0;
        rx_val = 1'b0;
        rx_beat = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        repeat (20) begin
            @(negedge clk);
            assert (!tx_val) else
                report_error("tx_val high after reset with no input");
            assert (drop_count == '0) else
                report_error($sformatf("drop_count %0d after reset, expected 0", drop_count));
        end

        send_frame(4, 3'd3);
        go_idle();
        wait_drain("the single frame");

        send_frame(1, 3'd0);        // one-beat and longest frames, back to back.
        send_frame(1, 3'd7);
        send_frame(`MAX_FRAME_BEATS, 3'd0);
        send_frame(`MAX_FRAME_BEATS, 3'd5);
        go_idle();
        wait_drain("the size check frames");

        repeat (12) send_random_frame();
        go_idle();
        wait_drain("the back-to-back frames");

        repeat (6) begin
            send_frame(`MAX_FRAME_BEATS, 3'(take_bits(3)));
            repeat (12) send_frame(1, 3'(take_bits(3)));  // short frames pile up behind the long one.
            send_random_frame();
        end
        go_idle();
        wait_drain("the burst frames");

        repeat (4) @(posedge clk);
        assert (frames_out + int'(drop_count) == frames_in) else
            report_error($sformatf("%0d frames out plus %0d dropped, expected %0d frames in",
                                   frames_out, drop_count, frames_in));

        $display("summary: %0d check errors, %0d timeouts, %0d frames in, %0d out, %0d dropped",
                 errors, timeouts, frames_in, frames_out, drop_count);
        if (errors == 0 && timeouts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/echo_subsystem_top.sv
`default_nettype none
`include "echo_defs.svh"

module echo_subsystem_top (
     input  wire                                clk
    ,input  wire                                rst_n

    ,input  wire                                rx_val
    ,input  wire mac_stream_pkg::mac_beat_t     rx_beat

    ,output logic                               tx_val
    ,output mac_stream_pkg::mac_beat_t          tx_beat
    ,output logic   [`MTU_SIZE_W-1:0]           tx_frame_size

    ,output logic   [15:0]                      drop_count
);

    logic                           wr_req;
    mac_stream_pkg::queue_entry_t   wr_entry;
    logic   [`QUEUE_LOG_ELS:0]      free_beats;

    logic                           rd_req;
    mac_stream_pkg::queue_entry_t   rd_entry;

    logic                           size_push;
    logic   [`MTU_SIZE_W-1:0]       size_data;
    logic                           size_pop;
    logic                           size_full;
    logic                           size_empty;
    logic   [`MTU_SIZE_W-1:0]       size_head;

    ////////////////////////////////////////
    // receive side.
    ////////////////////////////////////////

    rx_frame_admit admit (
         .clk           (clk            )
        ,.rst_n         (rst_n          )
        ,.rx_val        (rx_val         )
        ,.rx_beat       (rx_beat        )
        ,.free_beats    (free_beats     )
        ,.size_full     (size_full      )
        ,.wr_req        (wr_req         )
        ,.wr_entry      (wr_entry       )
        ,.size_push     (size_push      )
        ,.size_data     (size_data      )
        ,.drop_count    (drop_count     )
    );

    packet_queue pkt_queue (
         .clk           (clk            )
        ,.rst_n         (rst_n          )
        ,.wr_req        (wr_req         )
        ,.wr_entry      (wr_entry       )
        ,.rd_req        (rd_req         )
        ,.rd_entry      (rd_entry       )
        ,.free_beats    (free_beats     )
        ,.size_push     (size_push      )
        ,.size_data     (size_data      )
        ,.size_pop      (size_pop       )
        ,.size_full     (size_full      )
        ,.size_empty    (size_empty     )
        ,.size_head     (size_head      )
    );

    ////////////////////////////////////////
    // transmit side.
    ////////////////////////////////////////

    echo_responder responder (
         .clk           (clk            )
        ,.rst_n         (rst_n          )
        ,.size_empty    (size_empty     )
        ,.size_head     (size_head      )
        ,.size_pop      (size_pop       )
        ,.rd_entry      (rd_entry       )
        ,.rd_req        (rd_req         )
        ,.tx_val        (tx_val         )
        ,.tx_beat       (tx_beat        )
        ,.tx_frame_size (tx_frame_size  )
    );

endmodule

`default_nettype wire

// File: source/echo_responder.sv
`default_nettype none
`include "echo_defs.svh"

module echo_responder (
     input  wire                                clk
    ,input  wire                                rst_n

    ,input  wire                                size_empty
    ,input  wire    [`MTU_SIZE_W-1:0]           size_head
    ,output logic                               size_pop

    ,input  wire mac_stream_pkg::queue_entry_t  rd_entry
    ,output logic                               rd_req

    ,output logic                               tx_val
    ,output mac_stream_pkg::mac_beat_t          tx_beat
    ,output logic   [`MTU_SIZE_W-1:0]           tx_frame_size
);

    localparam logic st_idle = 1'b0;
    localparam logic st_stream = 1'b1;

    logic                           state_q;
    logic                           state_d;

    echo_header_pkg::first_beat_u   rx_hdr;
    echo_header_pkg::first_beat_u   tx_hdr;
    mac_stream_pkg::mac_beat_t      beat_d;

    ////////////////////////////////////////
    // frame pull FSM.
    ////////////////////////////////////////

    // a waiting size means every beat of that frame is already in the queue.
    always_comb begin
        state_d = state_q;
        size_pop = 1'b0;
        rd_req = 1'b0;
        case (state_q)
            st_idle: begin
                if (!size_empty) begin
                    size_pop = 1'b1;
                    rd_req = 1'b1;  // the start beat goes with the size.
                    if (!rd_entry.endframe) begin
                        state_d = st_stream;
                    end
                end
            end
            default: begin
                rd_req = 1'b1;
                if (rd_entry.endframe) begin
                    state_d = st_idle;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= st_idle;
            tx_val <= 1'b0;
        end else begin
            state_q <= state_d;
            tx_val <= rd_req;
        end
    end

    ////////////////////////////////////////
    // header swap.
    ////////////////////////////////////////

    always_comb begin
        rx_hdr.raw = rd_entry.data;
        tx_hdr = rx_hdr;
        tx_hdr.hdr.dst_id = rx_hdr.hdr.src_id;
        tx_hdr.hdr.src_id = rx_hdr.hdr.dst_id;

        // only the start beat carries a header, later beats pass as they are.
        beat_d.data = rd_entry.startframe ? tx_hdr.raw : rd_entry.data;
        beat_d.startframe = rd_entry.startframe;
        beat_d.endframe = rd_entry.endframe;
        beat_d.padbytes = rd_entry.padbytes;
    end

    always_ff @(posedge clk) begin
        if (rd_req) begin
            tx_beat <= beat_d;
        end
        if (size_pop) begin
            tx_frame_size <= size_head; // held for the start beat one cycle later.
        end
    end

endmodule

`default_nettype wire

// File: source/packet_queue.sv
`default_nettype none
`include "echo_defs.svh"

module packet_queue (
     input  wire                                clk
    ,input  wire                                rst_n

    ,input  wire                                wr_req
    ,input  wire mac_stream_pkg::queue_entry_t  wr_entry

    ,input  wire                                rd_req
    ,output mac_stream_pkg::queue_entry_t       rd_entry
    ,output logic   [`QUEUE_LOG_ELS:0]          free_beats

    ,input  wire                                size_push
    ,input  wire    [`MTU_SIZE_W-1:0]           size_data
    ,input  wire                                size_pop
    ,output logic                               size_full
    ,output logic                               size_empty
    ,output logic   [`MTU_SIZE_W-1:0]           size_head
);

    localparam int beat_els = 1 << `QUEUE_LOG_ELS;
    localparam int size_els = 1 << `SIZE_QUEUE_LOG_ELS;
    localparam logic [`QUEUE_LOG_ELS:0] beat_cap = (`QUEUE_LOG_ELS+1)'(beat_els);
    localparam logic [`SIZE_QUEUE_LOG_ELS:0] size_cap = (`SIZE_QUEUE_LOG_ELS+1)'(size_els);

    ////////////////////////////////////////
    // beat queue.
    ////////////////////////////////////////

    mac_stream_pkg::queue_entry_t       beat_mem [beat_els];

    logic   [`QUEUE_LOG_ELS-1:0]        beat_wr_ptr_q;
    logic   [`QUEUE_LOG_ELS-1:0]        beat_rd_ptr_q;
    logic   [`QUEUE_LOG_ELS:0]          beat_cnt_q;
    logic                               beat_wr;
    logic                               beat_rd;

    // the producer reserves room up front, so these guards only matter on misuse.
    assign beat_wr = wr_req & (beat_cnt_q != beat_cap);
    assign beat_rd = rd_req & (beat_cnt_q != '0);

    always_ff @(posedge clk) begin
        if (beat_wr) begin
            beat_mem[beat_wr_ptr_q] <= wr_entry;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_wr_ptr_q <= '0;
            beat_rd_ptr_q <= '0;
            beat_cnt_q <= '0;
        end else begin
            if (beat_wr) begin
                beat_wr_ptr_q <= beat_wr_ptr_q + 1'b1;  // wraps at the queue depth.
            end
            if (beat_rd) begin
                beat_rd_ptr_q <= beat_rd_ptr_q + 1'b1;
            end
            beat_cnt_q <= beat_cnt_q + (`QUEUE_LOG_ELS+1)'(beat_wr)
                                     - (`QUEUE_LOG_ELS+1)'(beat_rd);
        end
    end

    // show-ahead read of the head entry.
    assign rd_entry = beat_mem[beat_rd_ptr_q];
    assign free_beats = beat_cap - beat_cnt_q;

    ////////////////////////////////////////
    // frame size queue.
    ////////////////////////////////////////

    logic   [`MTU_SIZE_W-1:0]           size_mem [size_els];

    logic   [`SIZE_QUEUE_LOG_ELS-1:0]   size_wr_ptr_q;
    logic   [`SIZE_QUEUE_LOG_ELS-1:0]   size_rd_ptr_q;
    logic   [`SIZE_QUEUE_LOG_ELS:0]     size_cnt_q;
    logic                               size_wr;
    logic                               size_rd;

    // a size lands with the end beat, so a visible size means a complete frame.
    assign size_wr = size_push & ~size_full;
    assign size_rd = size_pop & ~size_empty;

    always_ff @(posedge clk) begin
        if (size_wr) begin
            size_mem[size_wr_ptr_q] <= size_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            size_wr_ptr_q <= '0;
            size_rd_ptr_q <= '0;
            size_cnt_q <= '0;
        end else begin
            if (size_wr) begin
                size_wr_ptr_q <= size_wr_ptr_q + 1'b1;
            end
            if (size_rd) begin
                size_rd_ptr_q <= size_rd_ptr_q + 1'b1;
            end
            size_cnt_q <= size_cnt_q + (`SIZE_QUEUE_LOG_ELS+1)'(size_wr)
                                     - (`SIZE_QUEUE_LOG_ELS+1)'(size_rd);
        end
    end

    assign size_full = (size_cnt_q == size_cap);
    assign size_empty = (size_cnt_q == '0);
    assign size_head = size_mem[size_rd_ptr_q];

endmodule

`default_nettype wire

// File: source/rx_frame_admit.sv
`default_nettype none
`include "echo_defs.svh"

module rx_frame_admit (
     input  wire                                clk
    ,input  wire                                rst_n

    ,input  wire                                rx_val
    ,input  wire mac_stream_pkg::mac_beat_t     rx_beat

    ,input  wire    [`QUEUE_LOG_ELS:0]          free_beats
    ,input  wire                                size_full

    ,output logic                               wr_req
    ,output mac_stream_pkg::queue_entry_t       wr_entry
    ,output logic                               size_push
    ,output logic   [`MTU_SIZE_W-1:0]           size_data
    ,output logic   [15:0]                      drop_count
);

    localparam logic [`MTU_SIZE_W-1:0] beat_bytes = `MTU_SIZE_W'(`MAC_INTERFACE_W / 8);
    localparam logic [`QUEUE_LOG_ELS:0] min_free = (`QUEUE_LOG_ELS+1)'(`MAX_FRAME_BEATS);

    logic                       keep_q;     // the current frame is being stored.
    logic   [`MTU_SIZE_W-1:0]   byte_cnt_q; // bytes of the frame before this beat.

    logic                       start_beat;
    logic                       end_beat;
    logic                       admit;
    logic                       keep_now;
    logic   [`MTU_SIZE_W-1:0]   byte_base;

    ////////////////////////////////////////
    // admission.
    ////////////////////////////////////////

    assign start_beat = rx_val & rx_beat.startframe;
    assign end_beat = rx_val & rx_beat.endframe;

    // room for the longest frame means the whole frame fits, whatever its length.
    assign admit = (free_beats >= min_free) & ~size_full;

    assign keep_now = start_beat ? admit : keep_q;

    ////////////////////////////////////////
    // writes into the buffer.
    ////////////////////////////////////////

    assign wr_req = rx_val & keep_now;
    assign wr_entry.data = rx_beat.data;
    assign wr_entry.startframe = rx_beat.startframe;
    assign wr_entry.endframe = rx_beat.endframe;
    assign wr_entry.padbytes = rx_beat.padbytes;

    // a start beat restarts the count, so a stale count never leaks in.
    assign byte_base = rx_beat.startframe ? '0 : byte_cnt_q;

    assign size_push = end_beat & keep_now;
    assign size_data = byte_base + beat_bytes - `MTU_SIZE_W'(rx_beat.padbytes);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            keep_q <= 1'b0;
            byte_cnt_q <= '0;
            drop_count <= '0;
        end else if (rx_val) begin
            keep_q <= keep_now & ~rx_beat.endframe; // leave the frame on its end beat.
            byte_cnt_q <= byte_base + beat_bytes;
            if (start_beat && !admit) begin
                drop_count <= drop_count + 16'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/echo_header_pkg.sv
`default_nettype none
`include "echo_defs.svh"

package echo_header_pkg;

    ////////////////////////////////////////
    // port header carried in the first beat.
    ////////////////////////////////////////

    typedef struct packed {
        logic   [15:0]  dst_id;     // most significant bytes of the beat.
        logic   [15:0]  src_id;
        logic   [15:0]  ethertype;
        logic   [15:0]  tag;
    } port_header_t;

    ////////////////////////////////////////
    // two views of the first beat.
    ////////////////////////////////////////

    // raw is what the queue holds, hdr is what the responder edits.
    typedef union packed {
        logic   [`MAC_INTERFACE_W-1:0]  raw;
        port_header_t                   hdr;
    } first_beat_u;

endpackage

`default_nettype wire

// File: source/mac_stream_pkg.sv
`default_nettype none
`include "echo_defs.svh"

package mac_stream_pkg;

    ////////////////////////////////////////
    // one beat on either mac side.
    ////////////////////////////////////////

    typedef struct packed {
        logic   [`MAC_INTERFACE_W-1:0]  data;
        logic                           startframe;
        logic                           endframe;
        logic   [`MAC_PADBYTES_W-1:0]   padbytes;   // only meaningful on the end beat.
    } mac_beat_t;

    ////////////////////////////////////////
    // one entry of the beat queue.
    ////////////////////////////////////////

    // the queue stores the beat as it arrived, framing bits included.
    typedef struct packed {
        logic   [`MAC_INTERFACE_W-1:0]  data;
        logic                           startframe;
        logic                           endframe;
        logic   [`MAC_PADBYTES_W-1:0]   padbytes;
    } queue_entry_t;

endpackage

`default_nettype wire

// File: source/echo_defs.svh
`ifndef ECHO_DEFS_SVH
`define ECHO_DEFS_SVH

////////////////////////////////////////
// mac stream widths.
////////////////////////////////////////

`define MAC_INTERFACE_W     64  // 8 bytes per beat.
`define MAC_PADBYTES_W      3
`define MTU_SIZE_W          8   // enough for a 16 beat frame of 128 bytes.

////////////////////////////////////////
// buffer sizing.
////////////////////////////////////////

`define QUEUE_LOG_ELS       6   // 64 beat entries.
`define SIZE_QUEUE_LOG_ELS  3   // 8 size entries.

// longest legal frame, also the space the producer reserves at a start beat.
`define MAX_FRAME_BEATS     16

`endif
